// File: include/gf_poly_table.svh
`ifndef GF_POLY_TABLE_SVH
`define GF_POLY_TABLE_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Primitive trinomials x^m + x^k + 1
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Widths 8, 12, 13 and 14 have no primitive trinomial and are absent.
// A field width that is not listed here maps to an all-zero polynomial.

localparam int trinomial_count = 9;

// Field width of each entry.
localparam int trinomial_m [trinomial_count] = '{
	3,
	4,
	5,
	6,
	7,
	9,
	10,
	11,
	15
};

// Exponent k of the middle term, in the same order as above.
localparam int trinomial_k [trinomial_count] = '{
	1,	// x^3 + x + 1.
	1,	// x^4 + x + 1.
	2,	// x^5 + x^2 + 1.
	1,	// x^6 + x + 1.
	1,	// x^7 + x + 1.
	4,	// x^9 + x^4 + 1.
	3,	// x^10 + x^3 + 1.
	2,	// x^11 + x^2 + 1.
	1	// x^15 + x + 1.
};

`endif

// File: hw/gf_pkg.sv
package gf_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Field element and limits
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int max_m = 15;	// Widest field supported.

	// One element in standard basis. A field of width M uses bits M-1:0.
	typedef logic [max_m-1:0] gf_elem_t;

	`include "gf_poly_table.svh"

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Field arithmetic
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Low terms of the field polynomial, with the x^m term left out.
	function automatic gf_elem_t field_poly(input int m);
		gf_elem_t taps;
		taps = '0;
		for (int e = 0; e < trinomial_count; e++) begin
			if (trinomial_m[e] == m)
				taps = gf_elem_t'((1 << trinomial_k[e]) | 1);
		end
		return taps;
	endfunction

	// One multiply by alpha is a shift with reduction on the carry out.
	function automatic gf_elem_t mul_alpha(input int m, input gf_elem_t a);
		gf_elem_t mask;
		gf_elem_t r;
		mask = gf_elem_t'((1 << m) - 1);
		r = (a << 1) & mask;
		if (a[m-1])
			r = r ^ field_poly(m);	// The x^m term folds back into the low terms.
		return r;
	endfunction

	// Alpha raised to k, reduced modulo the group order 2^m - 1.
	function automatic gf_elem_t alpha_pow(input int m, input int k);
		gf_elem_t r;
		int n;
		int steps;
		n = (1 << m) - 1;
		steps = k % n;
		r = gf_elem_t'(1);
		for (int s = 0; s < steps; s++)
			r = mul_alpha(m, r);
		return r;
	endfunction

	// Shift-and-add multiply of two elements.
	function automatic gf_elem_t gf_mul(input int m, input gf_elem_t a, input gf_elem_t b);
		gf_elem_t acc;
		gf_elem_t p;
		acc = '0;
		p = a;
		for (int i = 0; i < m; i++) begin
			if (b[i])
				acc = acc ^ p;	// Add a*alpha^i for each set bit of b.
			p = mul_alpha(m, p);
		end
		return acc;
	endfunction

endpackage

// File: hw/chien_pkg.sv
package chien_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Search limits and counters
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Largest error-locator degree. The polynomial has max_t+1
	// coefficients at most.
	localparam int max_t = 8;

	// Exponent i of the point alpha^i under test.
	// It runs from 0 to N-1, so it is as wide as the widest field.
	typedef logic [gf_pkg::max_m-1:0] exp_t;

	// Number of roots found in one scan.
	// A nonzero locator of degree T has at most T roots.
	// The all-zero polynomial hits every position, which is 15 for M = 4.
	typedef logic [3:0] count_t;

endpackage

// File: hw/gf_std_mul.sv
`timescale 1ns/100ps

// Bit-parallel standard-basis multiplier.
// One shared element in1 is multiplied by N_INPUT elements packed in in2.
// The shared ladder of in1*alpha^k blocks is built once and then reused
// by every product, so the cost per extra input is only the AND/XOR plane.
module gf_std_mul #(
	parameter int M = 4,
	parameter int N_INPUT = 1
) (
	input  logic [M-1:0]         in1,
	input  logic [M*N_INPUT-1:0] in2,
	output logic [M*N_INPUT-1:0] product
);

	import gf_pkg::*;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage 1, the alpha-shift ladder
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	logic [M-1:0] ladder [M];	// Entry k holds in1 * alpha^k.
	logic [M-1:0] column [M];	// Entry b holds bit b of every ladder entry.

	for (genvar k = 0; k < M; k++) begin : g_ladder
		if (k == 0) begin : g_first
			assign ladder[0] = in1;
		end else begin : g_next
			gf_elem_t shifted;

			// Each block is the previous one times alpha.
			assign shifted = mul_alpha(M, gf_elem_t'(ladder[k-1]));
			assign ladder[k] = shifted[M-1:0];
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stage 2, transpose and inner products
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Bit b of in1*in2 is the sum over k of in2[k] and bit b of ladder[k].
	// Gathering bit b of all ladder entries into one word turns that sum
	// into a single masked parity.
	for (genvar b = 0; b < M; b++) begin : g_column
		for (genvar k = 0; k < M; k++) begin : g_bit
			assign column[b][k] = ladder[k][b];
		end
	end

	for (genvar n = 0; n < N_INPUT; n++) begin : g_input
		for (genvar b = 0; b < M; b++) begin : g_out
			assign product[n*M+b] = ^(in2[n*M+:M] & column[b]);
		end
	end

endmodule

// File: hw/chien_step.sv
`timescale 1ns/100ps

// Term registers of the Chien search.
// Term j holds sigma_j * alpha^(i*j) for the current position i.
// Stepping to position i+1 multiplies term j by the constant alpha^j.
module chien_step #(
	parameter int M = 4,
	parameter int T = 3
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               load,
	input  logic               advance,
	input  logic [M*(T+1)-1:0] sigma,
	output logic [M*(T+1)-1:0] terms
);

	import gf_pkg::*;

	logic [M-1:0] term_q    [T+1];
	logic [M-1:0] term_next [T+1];	// Value of each term at the next position.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Constant multipliers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Term 0 is the constant coefficient and never changes during a scan.
	assign term_next[0] = term_q[0];

	for (genvar j = 1; j <= T; j++) begin : g_term
		localparam gf_elem_t alpha_full = alpha_pow(M, j);
		localparam logic [M-1:0] alpha_j = alpha_full[M-1:0];

		// With a constant in1 the ladder collapses to fixed XOR trees.
		gf_std_mul #(
			.M       (M),
			.N_INPUT (1)
		) mul_inst (
			.in1     (alpha_j),
			.in2     (term_q[j]),
			.product (term_next[j])
		);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Term registers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		for (int j = 0; j <= T; j++) begin
			if (load)
				term_q[j] <= sigma[j*M+:M];	// Position 0 evaluates sigma(1).
			else if (advance)
				term_q[j] <= term_next[j];
		end
	end

	for (genvar j = 0; j <= T; j++) begin : g_pack
		assign terms[j*M+:M] = term_q[j];
	end

	// A load during an advance would mix two polynomials in the term set.
	assert property (@(posedge clk) disable iff (reset) !(load && advance))
		else $error("chien_step saw load and advance in the same cycle.");

endmodule

// File: hw/chien_sum.sv
`timescale 1ns/100ps

// Evaluation sum and position counters of the Chien search.
// The XOR of all terms is sigma(alpha^i). The point alpha^i is kept
// by an LFSR, and a binary counter tracks the exponent i alongside it.
module chien_sum #(
	parameter int M = 4,
	parameter int T = 3
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               load,
	input  logic               advance,
	input  logic [M*(T+1)-1:0] terms,
	output logic               is_zero,
	output gf_pkg::gf_elem_t   point,
	output chien_pkg::exp_t    point_exp,
	output logic               last
);

	import gf_pkg::*;
	import chien_pkg::*;

	localparam logic [M-1:0] last_exp = M'((1 << M) - 2);	// N-1.

	logic [M*(T+1)-1:0] rearranged;
	logic [M-1:0]       eval;
	logic [M-1:0]       lfsr_q;
	logic [M-1:0]       exp_q;
	gf_elem_t           lfsr_next;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Evaluation value
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Group bit b of every term together so each output bit is one parity.
	for (genvar b = 0; b < M; b++) begin : g_bit
		for (genvar j = 0; j <= T; j++) begin : g_term
			assign rearranged[b*(T+1)+j] = terms[j*M+b];
		end
		assign eval[b] = ^rearranged[b*(T+1)+:T+1];
	end

	assign is_zero = ~|eval;	// alpha^i is a root of the locator.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Position counters
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign lfsr_next = mul_alpha(M, gf_elem_t'(lfsr_q));

	always_ff @(posedge clk) begin
		if (reset || load) begin
			lfsr_q <= M'(1);	// alpha^0.
			exp_q  <= '0;
		end else if (advance) begin
			lfsr_q <= lfsr_next[M-1:0];
			exp_q  <= exp_q + M'(1);
		end
	end

	assign point     = gf_elem_t'(lfsr_q);
	assign point_exp = exp_t'(exp_q);
	assign last      = (exp_q == last_exp);

	// Multiplying a nonzero element by alpha can never give zero.
	assert property (@(posedge clk) disable iff (reset) lfsr_q != '0)
		else $error("chien_sum point counter reached zero.");

endmodule

// File: hw/chien_search.sv
`timescale 1ns/100ps

// Chien search engine for a binary BCH decoder.
// Takes one error-locator polynomial, tests every nonzero field element
// in turn, and streams out each root. A done pulse ends every scan.
module chien_search #(
	parameter int M = 4,
	parameter int T = 3
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               sigma_valid,
	output logic               sigma_ready,
	input  logic [M*(T+1)-1:0] sigma_data,
	output logic               root_valid,
	input  logic               root_ready,
	output logic [M-1:0]       root_exp,
	output logic [M-1:0]       root_value,
	output logic               scan_done,
	output chien_pkg::count_t  root_count
);

	import gf_pkg::*;
	import chien_pkg::*;

	typedef enum logic [1:0] {
		st_idle,
		st_scan,
		st_finish
	} state_t;

	state_t       state;
	logic         load;
	logic         advance;
	logic [M*(T+1)-1:0] terms;
	logic         is_zero;
	gf_elem_t     point;
	exp_t         point_exp;
	logic         last;
	logic         out_free;
	logic         scan_step;
	logic         capture;
	count_t       root_cnt;

	// Reject widths that the field table or the term array cannot hold.
	if (M > max_m || field_poly(M) == '0) begin : g_check_m
		$error("No primitive trinomial field is defined for M = %0d.", M);
	end
	if (T < 1 || T > max_t) begin : g_check_t
		$error("Locator degree T = %0d is out of range.", T);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Datapath
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	chien_step #(
		.M       (M),
		.T       (T)
	) chien_step_inst (
		.clk     (clk),
		.reset   (reset),
		.load    (load),
		.advance (advance),
		.sigma   (sigma_data),
		.terms   (terms)
	);

	chien_sum #(
		.M         (M),
		.T         (T)
	) chien_sum_inst (
		.clk       (clk),
		.reset     (reset),
		.load      (load),
		.advance   (advance),
		.terms     (terms),
		.is_zero   (is_zero),
		.point     (point),
		.point_exp (point_exp),
		.last      (last)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Scan control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign sigma_ready = (state == st_idle);
	assign load        = sigma_valid && sigma_ready;

	// The output register can take a new record when it is empty or
	// when its current record leaves on this edge.
	assign out_free  = !root_valid || root_ready;
	assign scan_step = (state == st_scan) && (!is_zero || out_free);	// Position i is done.
	assign capture   = (state == st_scan) && is_zero && out_free;
	assign advance   = scan_step && !last;

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= st_idle;
			scan_done <= 1'b0;
			root_cnt  <= '0;
		end else begin
			scan_done <= 1'b0;
			case (state)
				st_idle: begin
					if (load) begin
						state    <= st_scan;
						root_cnt <= '0;
					end
				end
				st_scan: begin
					if (capture)
						root_cnt <= root_cnt + 4'd1;
					if (scan_step && last)
						state <= st_finish;	// Last position is handled.
				end
				st_finish: begin
					// Wait for the final root to drain, pulse done, then idle.
					if (scan_done)
						state <= st_idle;
					else if (out_free)
						scan_done <= 1'b1;
				end
				default: state <= st_idle;
			endcase
		end
	end

	assign root_count = root_cnt;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Root output register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (reset)
			root_valid <= 1'b0;
		else if (capture)
			root_valid <= 1'b1;
		else if (root_ready)
			root_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (capture) begin
			root_exp   <= point_exp[M-1:0];
			root_value <= point[M-1:0];	// alpha^root_exp.
		end
	end

	// A stalled record must not change until the sink takes it.
	assert property (@(posedge clk) disable iff (reset)
		root_valid && !root_ready |=> root_valid && $stable(root_exp) && $stable(root_value))
		else $error("Root record changed while stalled.");

	// The engine only reopens for a load right after a done pulse.
	assert property (@(posedge clk) disable iff (reset)
		$rose(sigma_ready) |-> $past(scan_done))
		else $error("sigma_ready rose without a preceding scan_done.");

endmodule

// File: test/chien_search_tb.sv
`timescale 1ns/100ps

// Testbench for the Chien search engine.
// Every polynomial in the trace is loaded in turn while a random sink
// throttles the root stream. Roots and counts are checked against the trace.
module chien_search_tb;

	import gf_pkg::*;
	import chien_pkg::*;

	localparam int M = 4;
	localparam int T = 3;
	localparam int N = (1 << M) - 1;
	localparam int reset_cycles = 16;

	// alpha^k for k = 0 to 14 in GF(16) built on x^4 + x + 1.
	localparam logic [M-1:0] alpha_table [N] = '{
		4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'h6, 4'hc, 4'hb,
		4'h5, 4'ha, 4'h7, 4'he, 4'hf, 4'hd, 4'h9
	};

	logic               clk;
	logic               reset;
	logic               sigma_valid;
	logic               sigma_ready;
	logic [M*(T+1)-1:0] sigma_data;
	logic               root_valid;
	logic               root_ready;
	logic [M-1:0]       root_exp;
	logic [M-1:0]       root_value;
	logic               scan_done;
	count_t             root_count;

	logic [M*(T+1)-1:0] trace_sigma [$];
	int                 trace_count [$];
	int                 trace_first [$];	// Where each root list starts in trace_exp.
	int                 trace_exp   [$];

	int cycle_count;
	int cycle_limit;
	int stall_left;	// Cycles left in a long sink stall.

	chien_search #(
		.M           (M),
		.T           (T)
	) chien_search_inst (
		.clk         (clk),
		.reset       (reset),
		.sigma_valid (sigma_valid),
		.sigma_ready (sigma_ready),
		.sigma_data  (sigma_data),
		.root_valid  (root_valid),
		.root_ready  (root_ready),
		.root_exp    (root_exp),
		.root_value  (root_value),
		.scan_done   (scan_done),
		.root_count  (root_count)
	);

	always #10 clk = ~clk;

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, the engine stopped making progress.", cycle_count);
			stop_run();
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic stop_run();
		$display("Regression failed");
		$fatal(1, "Simulation stopped on the first error.");
	endtask

	task automatic report_mismatch(input string msg);
		$display("FAIL at %0t: %s", $time, msg);
		stop_run();
	endtask

	task automatic check_root(input exp_t got_exp, input gf_elem_t got_value,
			input exp_t want_exp, input gf_elem_t want_value, input string what);
		if (got_exp !== want_exp || got_value !== want_value)
			report_mismatch($sformatf("%s, got exponent %0d value %h, expected %0d value %h",
				what, got_exp, got_value, want_exp, want_value));
	endtask

	task automatic check_count(input count_t got, input count_t want, input string what);
		if (got !== want)
			report_mismatch($sformatf("%s, got %0d, expected %0d", what, got, want));
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Each line holds sigma_0 to sigma_3, the root count and the exponents.
	task automatic read_trace();
		int                 fd;
		int                 value;
		int                 n_roots;
		logic [M*(T+1)-1:0] sigma;
		fd = $fopen("test/chien_trace.txt", "r");
		if (fd == 0) begin
			$display("Could not open the trace file test/chien_trace.txt.");
			stop_run();
		end
		while ($fscanf(fd, "%d", value) == 1) begin
			sigma[M-1:0] = M'(value);
			for (int j = 1; j <= T; j++) begin
				void'($fscanf(fd, "%d", value));
				sigma[j*M+:M] = M'(value);
			end
			void'($fscanf(fd, "%d", n_roots));
			trace_sigma.push_back(sigma);
			trace_count.push_back(n_roots);
			trace_first.push_back(trace_exp.size());
			for (int k = 0; k < n_roots; k++) begin
				void'($fscanf(fd, "%d", value));
				trace_exp.push_back(value);
			end
		end
		$fclose(fd);
	endtask

	task automatic drive_root_ready();
		int pick;
		if (stall_left > 0) begin
			root_ready = 1'b0;
			stall_left--;
		end else begin
			pick = int'($urandom % 16);
			if (pick == 0) begin
				stall_left = 8 + int'($urandom % 24);	// Long stall.
				root_ready = 1'b0;
			end else
				root_ready = (pick > 5);
		end
	endtask

	task automatic run_polynomial(input int p);
		int       next_root;
		int       e;
		bit       done;
		bit       stalled;
		exp_t     held_exp;
		gf_elem_t held_value;
		next_root = 0;
		done = 1'b0;
		stalled = 1'b0;
		held_exp = '0;
		held_value = '0;
		if (!sigma_ready)
			report_mismatch("sigma_ready is low while the engine should be idle");
		sigma_valid = 1'b1;
		sigma_data = trace_sigma[p];
		root_ready = 1'b0;
		@(negedge clk);
		sigma_valid = 1'b0;
		while (!done) begin
			if (sigma_ready)
				report_mismatch("sigma_ready is high during a scan");
			if (stalled) begin
				if (!root_valid)
					report_mismatch("root_valid dropped while the sink stalled");
				check_root(exp_t'(root_exp), gf_elem_t'(root_value), held_exp, held_value,
					"Stalled root record changed");
			end
			if (scan_done) begin
				if (root_valid)
					report_mismatch("Root record still pending at scan_done");
				check_count(root_count, count_t'(trace_count[p]), "root_count at scan_done");
				check_count(count_t'(next_root), count_t'(trace_count[p]), "Roots received");
				done = 1'b1;
			end else begin
				drive_root_ready();
				if (root_valid && root_ready) begin	// The record leaves on the next edge.
					if (next_root >= trace_count[p])
						report_mismatch($sformatf("Extra root at exponent %0d", root_exp));
					e = trace_exp[trace_first[p] + next_root];
					check_root(exp_t'(root_exp), gf_elem_t'(root_value), exp_t'(e),
						gf_elem_t'(alpha_table[e]), "Root record");
					next_root++;
				end
				stalled = root_valid && !root_ready;
				held_exp = exp_t'(root_exp);
				held_value = gf_elem_t'(root_value);
				@(negedge clk);
			end
		end
		root_ready = 1'b0;
		@(negedge clk);
		if (root_valid)
			report_mismatch("Root record appeared after scan_done");
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		sigma_valid = 1'b0;
		sigma_data = '0;
		root_ready = 1'b0;
		cycle_count = 0;
		stall_left = 0;
		void'($urandom(32'h80a5_eab9));
		read_trace();
		cycle_limit = trace_sigma.size() * (N + 1) * 8 + reset_cycles;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		if (root_valid || scan_done)
			report_mismatch("Root stream or done is active after reset");
		for (int p = 0; p < trace_sigma.size(); p++)
			run_polynomial(p);	// Loads follow each other with no idle gap.
		$display("Regression passed");
		$finish;
	end

endmodule

// File: test/chien_trace.txt
8 14 7 1 3 0 1 2
11 5 12 1 3 3 7 12
3 7 10 1 2 5 9
15 4 1 0 2 13 14
7 3 0 0 1 6
1 1 0 1 0
1 0 0 0 0
0 0 0 0 15 0 1 2 3 4 5 6 7 8 9 10 11 12 13 14
5 2 1 6 3 0 1 2
13 11 13 1 3 4 10 14
1 0 0 1 3 0 5 10
1 1 1 0 2 5 10
0 1 0 0 0
0 1 1 0 1 0
1 0 1 1 0
9 1 0 0 1 14
0 0 0 1 0
0 0 0 0 15 0 1 2 3 4 5 6 7 8 9 10 11 12 13 14
5 0 0 0 0

// File: chien_search.f
+incdir+include
hw/gf_pkg.sv
hw/chien_pkg.sv
hw/gf_std_mul.sv
hw/chien_step.sv
hw/chien_sum.sv
hw/chien_search.sv
test/chien_search_tb.sv

// File: Makefile
TOP = chien_search_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f chien_search.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f chien_search.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
